// ==== logic/lane_driver_pkg.sv ====
`default_nettype none

package lane_driver_pkg;

    ////////////////////////////////////////
    // Instruction types

    localparam int INST_TYPE_W = 3;

    localparam logic [INST_TYPE_W-1:0] INST_NORMAL = 3'd0;  // Read, then write after delay
    localparam logic [INST_TYPE_W-1:0] INST_STORE  = 3'd2;  // Read only, data goes to store unit
    localparam logic [INST_TYPE_W-1:0] INST_LOAD   = 3'd4;  // Write incoming beats

    ////////////////////////////////////////
    // Element widths

    localparam int SEW_W = 2;

    localparam logic [SEW_W-1:0] SEW_BYTE = 2'd0;
    localparam logic [SEW_W-1:0] SEW_HALF = 2'd1;
    localparam logic [SEW_W-1:0] SEW_WORD = 2'd2;

    // One lane word is four bytes wide
    localparam int BYTES_PER_WORD = 4;

    // Elements per word as a shift, used to turn an element count into a word offset
    function automatic logic [1:0] sew_shift(input logic [SEW_W-1:0] sew);
        case (sew)
            SEW_BYTE: return 2'd2;
            SEW_HALF: return 2'd1;
            default:  return 2'd0;  // Word and anything wider
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== logic/issue_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_ctrl import lane_driver_pkg::*; #(
    parameter int MEM_DEPTH       = 512,
    parameter int VLANE_NUM       = 8,
    parameter int MAX_VL_PER_LANE = 256
) (
    input  wire logic                                       clk_i,
    input  wire logic                                       rst_i,
    input  wire logic                                       start_i,
    input  wire logic [INST_TYPE_W-1:0]                     inst_type_i,
    input  wire logic [$clog2(VLANE_NUM*MAX_VL_PER_LANE):0] vl_i,
    input  wire logic [SEW_W-1:0]                           vsew_i,
    input  wire logic [SEW_W-1:0]                           wsew_i,
    input  wire logic [$clog2(MAX_VL_PER_LANE)-1:0]         inst_delay_i,
    input  wire logic [$clog2(MEM_DEPTH)-1:0]               raddr_base_i,
    input  wire logic [$clog2(MEM_DEPTH)-1:0]               waddr_base_i,
    input  wire logic                                       rd_done_i,
    input  wire logic                                       wr_done_i,
    output logic                                            ready_o,
    output logic                                            ready_for_load_o,
    output logic                                            store_data_valid_o,
    output logic                                            rd_start_o,
    output logic                                            wr_start_o,
    output logic                                            load_mode_o,
    output logic [$clog2(MAX_VL_PER_LANE):0]                elem_limit_o,
    output logic [$clog2(VLANE_NUM*MAX_VL_PER_LANE):0]      vl_o,
    output logic [SEW_W-1:0]                                vsew_o,
    output logic [SEW_W-1:0]                                wsew_o,
    output logic [$clog2(MAX_VL_PER_LANE)-1:0]              inst_delay_o,
    output logic [$clog2(MEM_DEPTH)-1:0]                    raddr_base_o,
    output logic [$clog2(MEM_DEPTH)-1:0]                    waddr_base_o
);

    localparam int EL_W   = $clog2(MAX_VL_PER_LANE) + 1;
    localparam int LANE_W = $clog2(VLANE_NUM);

    typedef enum logic [1:0] {IDLE, NORMAL, STORE, LOAD} state_t;

    state_t          state_q, state_d;
    logic            ready_q;
    logic            rd_seen_q;  // Read side already finished in NORMAL
    logic            accept;
    logic            finish;
    logic [EL_W-1:0] vl_ceil;

    assign accept = start_i && ready_q;

    // Elements per lane, rounded up
    assign vl_ceil = EL_W'(vl_i >> LANE_W) + EL_W'(|vl_i[LANE_W-1:0]);

    ////////////////////////////////////////
    // Completion per mode

    always_comb begin
        case (state_q)
            NORMAL:  finish = wr_done_i && (rd_seen_q || rd_done_i);
            STORE:   finish = rd_done_i;
            LOAD:    finish = wr_done_i;  // Beat with load_last_i
            default: finish = 1'b1;       // Unsupported code frees on the next edge
        endcase
    end

    always_comb begin
        state_d = state_q;
        if (state_q == IDLE) begin
            if (accept) begin
                case (inst_type_i)
                    INST_NORMAL: state_d = NORMAL;
                    INST_STORE:  state_d = STORE;
                    INST_LOAD:   state_d = LOAD;
                    default:     state_d = IDLE;
                endcase
            end
        end else if (finish) begin
            state_d = IDLE;
        end
    end

    ////////////////////////////////////////
    // Control state

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q    <= IDLE;
            ready_q    <= 1'b1;
            rd_seen_q  <= 1'b0;
            rd_start_o <= 1'b0;
            wr_start_o <= 1'b0;
        end else begin
            state_q    <= state_d;
            rd_start_o <= accept && (inst_type_i == INST_NORMAL || inst_type_i == INST_STORE);
            wr_start_o <= accept && (inst_type_i == INST_NORMAL);  // Loads start from load_mode_o
            if (accept) begin
                ready_q <= 1'b0;
            end else if (!ready_q && finish) begin
                ready_q <= 1'b1;
            end
            if (accept) begin
                rd_seen_q <= 1'b0;
            end else if (rd_done_i) begin
                rd_seen_q <= 1'b1;
            end
        end
    end

    // Instruction fields, held for the whole run
    always_ff @(posedge clk_i) begin
        if (accept) begin
            elem_limit_o <= vl_ceil;
            vl_o         <= vl_i;
            vsew_o       <= vsew_i;
            wsew_o       <= wsew_i;
            inst_delay_o <= inst_delay_i;
            raddr_base_o <= raddr_base_i;
            waddr_base_o <= waddr_base_i;
        end
    end

    assign ready_o          = ready_q;
    assign load_mode_o      = (state_q == LOAD);
    assign ready_for_load_o = (state_q == LOAD);  // Beat taken every cycle until the last

    // STORE state spans exactly the read cycles
    assign store_data_valid_o = (state_q == STORE) && (elem_limit_o != '0);

endmodule

`default_nettype wire

// ==== logic/read_port_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module read_port_gen import lane_driver_pkg::*; #(
    parameter int MEM_DEPTH       = 512,
    parameter int VLANE_NUM       = 8,
    parameter int MAX_VL_PER_LANE = 256
) (
    input  wire logic                                       clk_i,
    input  wire logic                                       rst_i,
    input  wire logic                                       rd_start_i,
    input  wire logic [$clog2(MAX_VL_PER_LANE):0]           elem_limit_i,
    input  wire logic [$clog2(VLANE_NUM*MAX_VL_PER_LANE):0] vl_i,
    input  wire logic [SEW_W-1:0]                           vsew_i,
    input  wire logic [$clog2(MEM_DEPTH)-1:0]               raddr_base_i,
    output logic                                            vrf_ren_o,
    output logic [$clog2(MEM_DEPTH)-1:0]                    vrf_raddr_o,
    output logic [VLANE_NUM-1:0]                            read_data_valid_o,
    output logic                                            rd_done_o
);

    localparam int AW     = $clog2(MEM_DEPTH);
    localparam int VL_W   = $clog2(VLANE_NUM*MAX_VL_PER_LANE) + 1;
    localparam int EL_W   = $clog2(MAX_VL_PER_LANE) + 1;
    localparam int LANE_W = $clog2(VLANE_NUM);

    logic            busy_q;
    logic [EL_W-1:0] cnt_q;      // Element index, back at zero between instructions
    logic            active;
    logic            last_elem;
    logic [VL_W-1:0] elem_base;  // Global index of lane 0 for this element

    assign active    = rd_start_i || busy_q;
    assign last_elem = (cnt_q + 1'b1) >= elem_limit_i;
    assign elem_base = VL_W'(cnt_q) << LANE_W;

    assign vrf_ren_o   = active && (cnt_q < elem_limit_i);
    assign rd_done_o   = active && last_elem;
    assign vrf_raddr_o = raddr_base_i + AW'(cnt_q >> sew_shift(vsew_i));

    // Lane valid while its element is inside vl
    always_comb begin
        for (int l = 0; l < VLANE_NUM; l++) begin
            read_data_valid_o[l] = vrf_ren_o && ((elem_base + VL_W'(l)) < vl_i);
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (active) begin
            if (last_elem) begin
                busy_q <= 1'b0;
                cnt_q  <= '0;
            end else begin
                busy_q <= 1'b1;
                cnt_q  <= cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/write_port_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module write_port_gen import lane_driver_pkg::*; #(
    parameter int MEM_DEPTH       = 512,
    parameter int VLANE_NUM       = 8,
    parameter int MAX_VL_PER_LANE = 256
) (
    input  wire logic                                       clk_i,
    input  wire logic                                       rst_i,
    input  wire logic                                       wr_start_i,
    input  wire logic                                       load_mode_i,
    input  wire logic                                       load_last_i,
    input  wire logic [VLANE_NUM*BYTES_PER_WORD-1:0]        load_bwen_i,
    input  wire logic [$clog2(MAX_VL_PER_LANE):0]           elem_limit_i,
    input  wire logic [$clog2(VLANE_NUM*MAX_VL_PER_LANE):0] vl_i,
    input  wire logic [SEW_W-1:0]                           wsew_i,
    input  wire logic [$clog2(MAX_VL_PER_LANE)-1:0]         inst_delay_i,
    input  wire logic [$clog2(MEM_DEPTH)-1:0]               waddr_base_i,
    output logic [$clog2(MEM_DEPTH)-1:0]                    vrf_waddr_o,
    output logic [VLANE_NUM*BYTES_PER_WORD-1:0]             vrf_bwen_o,
    output logic                                            wr_done_o
);

    localparam int AW     = $clog2(MEM_DEPTH);
    localparam int VL_W   = $clog2(VLANE_NUM*MAX_VL_PER_LANE) + 1;
    localparam int EL_W   = $clog2(MAX_VL_PER_LANE) + 1;
    localparam int DLY_W  = $clog2(MAX_VL_PER_LANE);
    localparam int LANE_W = $clog2(VLANE_NUM);

    logic                      wait_q;   // Counting off inst_delay
    logic                      busy_q;   // Past the first write
    logic [DLY_W-1:0]          dly_q;
    logic [EL_W-1:0]           cnt_q;    // Element index, or beat index in load mode
    logic                      dly_hit;
    logic                      write_act;
    logic                      last_elem;
    logic [VL_W-1:0]           elem_base;
    logic [BYTES_PER_WORD-1:0] pattern;

    assign dly_hit   = wait_q && (dly_q >= inst_delay_i);  // First write lands here
    assign write_act = dly_hit || busy_q;
    assign last_elem = (cnt_q + 1'b1) >= elem_limit_i;
    assign elem_base = VL_W'(cnt_q) << LANE_W;

    assign wr_done_o = load_mode_i ? load_last_i : (write_act && last_elem);

    // Loads write one word per beat, no packing by width
    assign vrf_waddr_o = load_mode_i ? waddr_base_i + AW'(cnt_q)
                                     : waddr_base_i + AW'(cnt_q >> sew_shift(wsew_i));

    ////////////////////////////////////////
    // Byte enables

    // Rotates with the element index inside one word
    always_comb begin
        case (wsew_i)
            SEW_BYTE: pattern = BYTES_PER_WORD'(1) << cnt_q[1:0];
            SEW_HALF: pattern = {{2{cnt_q[0]}}, {2{~cnt_q[0]}}};
            default:  pattern = '1;
        endcase
    end

    always_comb begin
        for (int l = 0; l < VLANE_NUM; l++) begin
            if (load_mode_i) begin
                vrf_bwen_o[l*BYTES_PER_WORD +: BYTES_PER_WORD] =
                    load_bwen_i[l*BYTES_PER_WORD +: BYTES_PER_WORD];
            end else if (write_act && ((elem_base + VL_W'(l)) < vl_i)) begin
                vrf_bwen_o[l*BYTES_PER_WORD +: BYTES_PER_WORD] = pattern;
            end else begin
                vrf_bwen_o[l*BYTES_PER_WORD +: BYTES_PER_WORD] = '0;  // Tail lanes stay untouched
            end
        end
    end

    ////////////////////////////////////////
    // Counters

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wait_q <= 1'b0;
            busy_q <= 1'b0;
            dly_q  <= '0;
            cnt_q  <= '0;
        end else if (load_mode_i) begin
            cnt_q <= load_last_i ? '0 : cnt_q + 1'b1;
        end else begin
            if (wr_start_i) begin
                wait_q <= 1'b1;
                dly_q  <= DLY_W'(1);
            end else if (wait_q && !dly_hit) begin
                dly_q <= dly_q + 1'b1;
            end
            if (write_act) begin
                wait_q <= 1'b0;
                busy_q <= !last_elem;
                cnt_q  <= last_elem ? '0 : cnt_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/sublane_driver.sv ====
`timescale 1ns/100ps
`default_nettype none

module sublane_driver import lane_driver_pkg::*; #(
    parameter int MEM_DEPTH       = 512,
    parameter int VLANE_NUM       = 8,
    parameter int MAX_VL_PER_LANE = 256
) (
    input  wire logic                                  clk_i,
    input  wire logic                                  rst_i,
    input  wire logic                                  start_i,
    input  wire logic [INST_TYPE_W-1:0]                inst_type_i,
    input  wire logic [$clog2(VLANE_NUM*MAX_VL_PER_LANE):0] vl_i,
    input  wire logic [SEW_W-1:0]                      vsew_i,
    input  wire logic [SEW_W-1:0]                      wsew_i,
    input  wire logic [$clog2(MAX_VL_PER_LANE)-1:0]    inst_delay_i,
    input  wire logic [$clog2(MEM_DEPTH)-1:0]          vrf_starting_raddr_i,
    input  wire logic [$clog2(MEM_DEPTH)-1:0]          vrf_starting_waddr_i,
    input  wire logic                                  load_last_i,
    input  wire logic [VLANE_NUM*BYTES_PER_WORD-1:0]   load_bwen_i,
    output logic                                       ready_o,
    output logic                                       ready_for_load_o,
    output logic                                       store_data_valid_o,
    output logic                                       vrf_ren_o,
    output logic [$clog2(MEM_DEPTH)-1:0]               vrf_raddr_o,
    output logic [VLANE_NUM-1:0]                       read_data_valid_o,
    output logic [$clog2(MEM_DEPTH)-1:0]               vrf_waddr_o,
    output logic [VLANE_NUM*BYTES_PER_WORD-1:0]        vrf_bwen_o
);

    localparam int AW    = $clog2(MEM_DEPTH);
    localparam int VL_W  = $clog2(VLANE_NUM*MAX_VL_PER_LANE) + 1;
    localparam int EL_W  = $clog2(MAX_VL_PER_LANE) + 1;
    localparam int DLY_W = $clog2(MAX_VL_PER_LANE);

    // Controller to generators
    logic             rd_start, wr_start, load_mode;
    logic [EL_W-1:0]  elem_limit;
    logic [VL_W-1:0]  vl;
    logic [SEW_W-1:0] vsew, wsew;
    logic [DLY_W-1:0] inst_delay;
    logic [AW-1:0]    raddr_base, waddr_base;

    // Generators back to controller
    logic rd_done, wr_done;

    issue_ctrl #(
        .MEM_DEPTH       (MEM_DEPTH),
        .VLANE_NUM       (VLANE_NUM),
        .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
    ) issue_ctrl_i (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .start_i            (start_i),
        .inst_type_i        (inst_type_i),
        .vl_i               (vl_i),
        .vsew_i             (vsew_i),
        .wsew_i             (wsew_i),
        .inst_delay_i       (inst_delay_i),
        .raddr_base_i       (vrf_starting_raddr_i),
        .waddr_base_i       (vrf_starting_waddr_i),
        .rd_done_i          (rd_done),
        .wr_done_i          (wr_done),
        .ready_o            (ready_o),
        .ready_for_load_o   (ready_for_load_o),
        .store_data_valid_o (store_data_valid_o),
        .rd_start_o         (rd_start),
        .wr_start_o         (wr_start),
        .load_mode_o        (load_mode),
        .elem_limit_o       (elem_limit),
        .vl_o               (vl),
        .vsew_o             (vsew),
        .wsew_o             (wsew),
        .inst_delay_o       (inst_delay),
        .raddr_base_o       (raddr_base),
        .waddr_base_o       (waddr_base)
    );

    read_port_gen #(
        .MEM_DEPTH       (MEM_DEPTH),
        .VLANE_NUM       (VLANE_NUM),
        .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
    ) read_port_gen_i (
        .clk_i             (clk_i),
        .rst_i             (rst_i),
        .rd_start_i        (rd_start),
        .elem_limit_i      (elem_limit),
        .vl_i              (vl),
        .vsew_i            (vsew),
        .raddr_base_i      (raddr_base),
        .vrf_ren_o         (vrf_ren_o),
        .vrf_raddr_o       (vrf_raddr_o),
        .read_data_valid_o (read_data_valid_o),
        .rd_done_o         (rd_done)
    );

    write_port_gen #(
        .MEM_DEPTH       (MEM_DEPTH),
        .VLANE_NUM       (VLANE_NUM),
        .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
    ) write_port_gen_i (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .wr_start_i   (wr_start),
        .load_mode_i  (load_mode),
        .load_last_i  (load_last_i),
        .load_bwen_i  (load_bwen_i),
        .elem_limit_i (elem_limit),
        .vl_i         (vl),
        .wsew_i       (wsew),
        .inst_delay_i (inst_delay),
        .waddr_base_i (waddr_base),
        .vrf_waddr_o  (vrf_waddr_o),
        .vrf_bwen_o   (vrf_bwen_o),
        .wr_done_o    (wr_done)
    );

endmodule

`default_nettype wire

// ==== tests/tb_expect.svh ====
`ifndef TB_EXPECT_SVH
`define TB_EXPECT_SVH

// One xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

// Word holding element k, four bytes per word
function automatic int word_offset(input int k, input int sew);
    case (sew)
        SEW_BYTE: return k / 4;
        SEW_HALF: return k / 2;
        default:  return k;
    endcase
endfunction

// Lanes whose element index is below vl
function automatic logic [VLANE_NUM-1:0] lane_mask(input int k, input int vlen);
    logic [VLANE_NUM-1:0] m;
    for (int l = 0; l < VLANE_NUM; l++) begin
        m[l] = (k * VLANE_NUM + l) < vlen;
    end
    return m;
endfunction

function automatic logic [BYTES_PER_WORD-1:0] lane_pattern(input int k, input int wsew_v);
    if (wsew_v == SEW_BYTE) begin
        case (k % 4)
            0:       return 4'b0001;
            1:       return 4'b0010;
            2:       return 4'b0100;
            default: return 4'b1000;
        endcase
    end else if (wsew_v == SEW_HALF) begin
        return (k % 2 == 0) ? 4'b0011 : 4'b1100;
    end
    return 4'b1111;
endfunction

// Full byte-enable word, tail lanes cleared
function automatic logic [VLANE_NUM*BYTES_PER_WORD-1:0] write_bwen(input int k, input int wsew_v,
                                                                   input int vlen);
    logic [VLANE_NUM-1:0]                m;
    logic [VLANE_NUM*BYTES_PER_WORD-1:0] b;
    m = lane_mask(k, vlen);
    for (int l = 0; l < VLANE_NUM; l++) begin
        b[l*BYTES_PER_WORD +: BYTES_PER_WORD] = m[l] ? lane_pattern(k, wsew_v) : 4'b0000;
    end
    return b;
endfunction

`endif

// ==== tests/sublane_driver_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module sublane_driver_tb import lane_driver_pkg::*; ();

    localparam int MEM_DEPTH       = 512;
    localparam int VLANE_NUM       = 8;
    localparam int MAX_VL_PER_LANE = 256;
    localparam int AW    = $clog2(MEM_DEPTH);
    localparam int VL_W  = $clog2(VLANE_NUM*MAX_VL_PER_LANE) + 1;
    localparam int DLY_W = $clog2(MAX_VL_PER_LANE);
    localparam int BW    = VLANE_NUM*BYTES_PER_WORD;
    localparam logic [INST_TYPE_W-1:0] INST_BAD = 3'd1;

    `include "tb_expect.svh"

    logic                   clk;
    logic                   rst;
    logic                   start;
    logic [INST_TYPE_W-1:0] inst_type;
    logic [VL_W-1:0]        vl;
    logic [SEW_W-1:0]       vsew;
    logic [SEW_W-1:0]       wsew;
    logic [DLY_W-1:0]       inst_delay;
    logic [AW-1:0]          raddr_base;
    logic [AW-1:0]          waddr_base;
    logic                   load_last;
    logic [BW-1:0]          load_bwen;
    logic                   ready;
    logic                   ready_for_load;
    logic                   store_valid;
    logic                   vrf_ren;
    logic [AW-1:0]          vrf_raddr;
    logic [VLANE_NUM-1:0]   rd_valid;
    logic [AW-1:0]          vrf_waddr;
    logic [BW-1:0]          vrf_bwen;

    logic [31:0] rng_state   = 32'd8;
    int          err_cnt     = 0;
    int          pass_cnt    = 0;
    int          fail_cnt    = 0;
    int          cycle_cnt   = 0;
    int          cycle_limit = 50 + 10;  // Margin plus reset and drain

    // Reference model of the running instruction
    int                     cyc;
    int                     end_cyc;  // Last busy cycle
    logic [INST_TYPE_W-1:0] m_type;
    int                     m_vl, m_vsew, m_wsew, m_dly, m_rbase, m_wbase, m_elim;

    sublane_driver #(
        .MEM_DEPTH       (MEM_DEPTH),
        .VLANE_NUM       (VLANE_NUM),
        .MAX_VL_PER_LANE (MAX_VL_PER_LANE)
    ) sublane_driver_i (
        .clk_i                (clk),
        .rst_i                (rst),
        .start_i              (start),
        .inst_type_i          (inst_type),
        .vl_i                 (vl),
        .vsew_i               (vsew),
        .wsew_i               (wsew),
        .inst_delay_i         (inst_delay),
        .vrf_starting_raddr_i (raddr_base),
        .vrf_starting_waddr_i (waddr_base),
        .load_last_i          (load_last),
        .load_bwen_i          (load_bwen),
        .ready_o              (ready),
        .ready_for_load_o     (ready_for_load),
        .store_data_valid_o   (store_valid),
        .vrf_ren_o            (vrf_ren),
        .vrf_raddr_o          (vrf_raddr),
        .read_data_valid_o    (rd_valid),
        .vrf_waddr_o          (vrf_waddr),
        .vrf_bwen_o           (vrf_bwen)
    );

    function automatic logic [31:0] next_word();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int rand_below(input int span);
        return int'(next_word() % span);
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
        assert (act_v === exp_v) else begin
            $display("[ERROR] %s expected %h got %h", name, exp_v, act_v);
            err_cnt++;
        end
    endtask

    // Waits for ready, issues one instruction, feeds load beats, waits for ready again
    task automatic issue_inst(input logic [INST_TYPE_W-1:0] itype, input int vlen,
                              input int rsew, input int wsew_v, input int dly,
                              input int beats, input bit hold_start);
        int j;
        while (!ready) @(negedge clk);
        cycle_limit += (vlen + VLANE_NUM - 1) / VLANE_NUM + dly + beats + 6;
        start      = 1'b1;
        inst_type  = itype;
        vl         = VL_W'(vlen);
        vsew       = SEW_W'(rsew);
        wsew       = SEW_W'(wsew_v);
        inst_delay = DLY_W'(dly);
        raddr_base = AW'(rand_below(MEM_DEPTH));
        waddr_base = AW'(rand_below(MEM_DEPTH));
        @(negedge clk);
        if (hold_start) begin
            // Changed fields that a busy driver must not take
            inst_type  = INST_STORE;
            vl         = VL_W'(vlen + VLANE_NUM);
            raddr_base = ~raddr_base;
            waddr_base = ~waddr_base;
            @(negedge clk);
        end
        start = 1'b0;
        for (j = 0; j < beats; j++) begin
            load_bwen = next_word();
            load_last = (j == beats - 1);
            @(negedge clk);
        end
        load_last = 1'b0;
        load_bwen = '0;
        @(negedge clk);
        while (!ready) @(negedge clk);
    endtask

    task automatic report_test(input string name, input int mark);
        if (err_cnt == mark) begin
            pass_cnt++;
            $display("%-16s passed", name);
        end else begin
            fail_cnt++;
            $display("%-16s failed with %0d errors", name, err_cnt - mark);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout after %0d cycles, the driver never returned to ready", cycle_cnt);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Scoreboard sampled on the rising edge

    always @(posedge clk) begin
        logic          rd_e;
        logic          wr_e;
        logic          rfl_e;
        logic          rdy_e;
        logic [BW-1:0] bwen_e;
        int            k;
        if (!rst) begin
            cyc     = 1000;
            end_cyc = 0;
            m_type  = INST_BAD;  // Idle looks like a finished no-op
        end else begin
            rdy_e = cyc > end_cyc;
            rd_e  = (m_type == INST_NORMAL || m_type == INST_STORE) && cyc >= 1 && cyc <= m_elim;
            wr_e  = (m_type == INST_NORMAL) && cyc >= 1 + m_dly && cyc <= m_elim + m_dly;
            rfl_e = (m_type == INST_LOAD) && cyc >= 1 && cyc <= end_cyc;
            check_value("ready_o", rdy_e, ready);
            check_value("vrf_ren_o", rd_e, vrf_ren);
            check_value("store_data_valid_o", rd_e && m_type == INST_STORE, store_valid);
            check_value("ready_for_load_o", rfl_e, ready_for_load);
            k = cyc - 1;
            if (rd_e) begin
                check_value("read_data_valid_o", lane_mask(k, m_vl), rd_valid);
                check_value("vrf_raddr_o", (m_rbase + word_offset(k, m_vsew)) % MEM_DEPTH,
                            vrf_raddr);
            end else begin
                check_value("read_data_valid_o", '0, rd_valid);
            end
            bwen_e = '0;
            if (wr_e) begin
                k      = cyc - 1 - m_dly;
                bwen_e = write_bwen(k, m_wsew, m_vl);
                check_value("vrf_waddr_o", (m_wbase + word_offset(k, m_wsew)) % MEM_DEPTH,
                            vrf_waddr);
            end
            if (rfl_e) begin
                bwen_e = load_bwen;  // Beat cyc-1
                check_value("vrf_waddr_o", (m_wbase + cyc - 1) % MEM_DEPTH, vrf_waddr);
            end
            check_value("vrf_bwen_o", bwen_e, vrf_bwen);

            if (rfl_e && load_last) begin
                end_cyc = cyc;
            end
            if (start && rdy_e) begin
                m_type  = inst_type;
                m_vl    = vl;
                m_vsew  = vsew;
                m_wsew  = wsew;
                m_dly   = inst_delay;
                m_rbase = raddr_base;
                m_wbase = waddr_base;
                m_elim  = (m_vl + VLANE_NUM - 1) / VLANE_NUM;
                case (inst_type)
                    INST_NORMAL: end_cyc = m_elim + m_dly;
                    INST_STORE:  end_cyc = m_elim;
                    INST_LOAD:   end_cyc = 1 << 30;  // Set by the last beat
                    default:     end_cyc = 1;
                endcase
                cyc = 1;
            end else begin
                cyc++;
            end
        end
    end

    ////////////////////////////////////////
    // Test sequence

    initial begin
        int i;
        int vlen;
        int vs;
        int ws;
        int dly;
        int mark;
        rst        = 1'b0;
        start      = 1'b0;
        inst_type  = INST_NORMAL;
        vl         = '0;
        vsew       = SEW_BYTE;
        wsew       = SEW_BYTE;
        inst_delay = '0;
        raddr_base = '0;
        waddr_base = '0;
        load_last  = 1'b0;
        load_bwen  = '0;
        mark       = err_cnt;
        repeat (3) @(negedge clk);
        rst = 1'b1;
        @(negedge clk);

        issue_inst(INST_NORMAL, 20, SEW_WORD, SEW_WORD, 2, 0, 1'b1);
        report_test("reset_handshake", mark);

        mark = err_cnt;
        for (i = 0; i < 4; i++) begin
            vlen = (i == 0) ? 13 : 1 + rand_below(64);  // First one has a tail
            vs   = rand_below(3);
            ws   = rand_below(3);
            dly  = 1 + rand_below(4);
            issue_inst(INST_NORMAL, vlen, vs, ws, dly, 0, 1'b0);
        end
        report_test("normal_reads", mark);

        mark = err_cnt;
        for (i = 0; i < 3; i++) begin
            vlen = VLANE_NUM * (1 + rand_below(6)) + 1 + rand_below(VLANE_NUM - 1);
            dly  = 1 + rand_below(8);
            issue_inst(INST_NORMAL, vlen, SEW_WORD, i, dly, 0, 1'b0);  // Byte, half, word
        end
        report_test("normal_writes", mark);

        mark = err_cnt;
        for (i = 0; i < 3; i++) begin
            vlen = 1 + rand_below(64);
            vs   = rand_below(3);
            issue_inst(INST_STORE, vlen, vs, SEW_WORD, 1 + rand_below(4), 0, 1'b0);
        end
        report_test("store", mark);

        mark = err_cnt;
        for (i = 0; i < 3; i++) begin
            issue_inst(INST_LOAD, 16, SEW_WORD, SEW_WORD, 1, 1 + rand_below(6), 1'b0);
        end
        report_test("load", mark);

        mark = err_cnt;
        issue_inst(INST_BAD, 24, SEW_BYTE, SEW_BYTE, 3, 0, 1'b0);
        issue_inst(3'd6, 24, SEW_BYTE, SEW_BYTE, 3, 0, 1'b0);
        report_test("unsupported", mark);

        repeat (3) @(negedge clk);
        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (err_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+tests
logic/lane_driver_pkg.sv
logic/issue_ctrl.sv
logic/read_port_gen.sv
logic/write_port_gen.sv
logic/sublane_driver.sv
tests/sublane_driver_tb.sv
